// ==== hw/lsuCfgPkg.sv ====
package lsuCfgPkg;

	// word sizes seen by the memory side
	localparam int DataW = 32;          // data word width
	localparam int AddrW = 32;          // word address width

	// entries per queue, power of two from 4 to 32
	localparam int DefaultLsqDepth = 8;

endpackage

// ==== hw/lsuPktPkg.sv ====
package lsuPktPkg;

	typedef logic [lsuCfgPkg::DataW-1:0] dataT;  // one data word
	typedef logic [lsuCfgPkg::AddrW-1:0] addrT;  // one word address

	// load queue entry, address known once the load has executed
	typedef struct packed
	{
		logic executed;                 // agen seen, memory read done
		addrT addr;                     // word address of the load
	} ldqEntryT;

	// store queue entry, filled in at agen
	typedef struct packed
	{
		logic addrValid;                // address and data known
		addrT addr;                     // word address of the store
		dataT data;                     // word to write at commit
	} stqEntryT;

endpackage

// ==== hw/lsqEntryRam.sv ====
`timescale 1ns/10ps

module lsqEntryRam #(
	parameter int  LsqDepth = lsuCfgPkg::DefaultLsqDepth,
	parameter type EntryT   = lsuPktPkg::ldqEntryT
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         clear_i,
	input  logic                         alloc_i,
	input  logic [$clog2(LsqDepth)-1:0]  allocIdx_i,
	input  logic                         updEn_i,
	input  logic [$clog2(LsqDepth)-1:0]  updIdx_i,
	input  EntryT                        updEntry_i,
	input  logic [$clog2(LsqDepth)-1:0]  headIdx_i,
	output EntryT                        entries_o [LsqDepth],
	output EntryT                        headEntry_o
);

	EntryT entryMem [LsqDepth];   // valid flags live inside the entries

	always_ff @(posedge clk)
	begin
		if (reset || clear_i)
		begin
			for (int i = 0; i < LsqDepth; i++)
				entryMem[i] <= '0;   // squash drops every flag
		end
		else
		begin
			if (alloc_i)
				entryMem[allocIdx_i] <= '0;          // new slot, nothing known yet
			if (updEn_i)
				entryMem[updIdx_i] <= updEntry_i;    // agen fills the slot
		end
	end

	assign entries_o   = entryMem;             // full view for the CAMs
	assign headEntry_o = entryMem[headIdx_i];  // oldest entry

endmodule

// ==== hw/storeForwardCam.sv ====
`timescale 1ns/10ps

module storeForwardCam #(
	parameter int LsqDepth = lsuCfgPkg::DefaultLsqDepth
) (
	input  lsuPktPkg::addrT              loadAddr_i,
	input  logic [$clog2(LsqDepth)-1:0]  stqHead_i,
	input  logic [$clog2(LsqDepth)-1:0]  stqBound_i,
	input  lsuPktPkg::stqEntryT          stqEntries_i [LsqDepth],
	output logic                         fwdHit_o,
	output lsuPktPkg::dataT              fwdData_o
);

	import lsuPktPkg::*;

	localparam int IdxW = $clog2(LsqDepth);

	logic [IdxW-1:0]     olderCnt;    // stores older than the load
	logic [IdxW-1:0]     entryOff;    // distance of an entry from the head
	logic [IdxW-1:0]     scanIdx;
	logic [LsqDepth-1:0] olderMask;   // entries between head and boundary
	logic [LsqDepth-1:0] addrMatch;   // known address equal to the load's
	logic [LsqDepth-1:0] fwdVec;
	stqEntryT            hitEntry;

	// mask and match per entry
	always_comb
	begin
		olderCnt = stqBound_i - stqHead_i;
		for (int i = 0; i < LsqDepth; i++)
		begin
			entryOff     = IdxW'(i) - stqHead_i;
			olderMask[i] = entryOff < olderCnt;
			// unknown addresses never match, so the load goes ahead
			addrMatch[i] = stqEntries_i[i].addrValid && (stqEntries_i[i].addr == loadAddr_i);
		end
		fwdVec = olderMask & addrMatch;
	end

	// walk oldest to youngest, the last hit is the youngest older store
	always_comb
	begin
		fwdHit_o = 1'b0;
		hitEntry = '0;
		for (int k = 0; k < LsqDepth; k++)
		begin
			scanIdx = stqHead_i + IdxW'(k);
			if (fwdVec[scanIdx])
			begin
				fwdHit_o = 1'b1;
				hitEntry = stqEntries_i[scanIdx];
			end
		end
		fwdData_o = hitEntry.data;
	end

endmodule

// ==== hw/loadViolationCam.sv ====
`timescale 1ns/10ps

module loadViolationCam #(
	parameter int LsqDepth = lsuCfgPkg::DefaultLsqDepth
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         recoverFlag_i,
	input  logic                         storeValid_i,
	input  lsuPktPkg::addrT              storeAddr_i,
	input  logic [$clog2(LsqDepth)-1:0]  ldqBound_i,
	input  logic [$clog2(LsqDepth)-1:0]  ldqTail_i,
	input  lsuPktPkg::ldqEntryT          ldqEntries_i [LsqDepth],
	output logic                         ldVioValid_o,
	output logic [$clog2(LsqDepth)-1:0]  ldVioLsqId_o
);

	localparam int IdxW = $clog2(LsqDepth);

	logic [IdxW-1:0]     youngerCnt;   // loads dispatched after the store
	logic [IdxW-1:0]     entryOff;
	logic [IdxW-1:0]     scanIdx;
	logic [LsqDepth-1:0] youngerMask;
	logic [LsqDepth-1:0] vioVec;       // executed younger loads, same word
	logic                vioHit;
	logic [IdxW-1:0]     vioIdx;

	always_comb
	begin
		youngerCnt = ldqTail_i - ldqBound_i;
		for (int i = 0; i < LsqDepth; i++)
		begin
			entryOff       = IdxW'(i) - ldqBound_i;
			youngerMask[i] = entryOff < youngerCnt;
			vioVec[i]      = youngerMask[i] && ldqEntries_i[i].executed
				&& (ldqEntries_i[i].addr == storeAddr_i);
		end
	end

	// first hit from the boundary is the oldest offender
	always_comb
	begin
		vioHit = 1'b0;
		vioIdx = '0;
		for (int k = 0; k < LsqDepth; k++)
		begin
			scanIdx = ldqBound_i + IdxW'(k);
			if (vioVec[scanIdx] && !vioHit)
			begin
				vioHit = 1'b1;
				vioIdx = scanIdx;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			ldVioValid_o <= 1'b0;
		else
			ldVioValid_o <= storeValid_i && vioHit && !recoverFlag_i;   // dropped on squash
	end

	always_ff @(posedge clk)
	begin
		if (storeValid_i && vioHit)
			ldVioLsqId_o <= vioIdx;
	end

endmodule

// ==== hw/lsuWriteback.sv ====
`timescale 1ns/10ps

module lsuWriteback #(
	parameter int LsqDepth = lsuCfgPkg::DefaultLsqDepth
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         recoverFlag_i,
	input  logic                         memValid_i,
	input  logic                         memIsLoad_i,
	input  logic [$clog2(LsqDepth)-1:0]  memLsqId_i,
	input  logic                         fwdHit_i,
	input  lsuPktPkg::dataT              fwdData_i,
	input  lsuPktPkg::dataT              ldData_i,
	output logic                         wbValid_o,
	output logic                         wbIsLoad_o,
	output logic [$clog2(LsqDepth)-1:0]  wbLsqId_o,
	output lsuPktPkg::dataT              wbData_o
);

	import lsuPktPkg::*;

	logic                        s1Valid;     // packet waiting for memory data
	logic                        s1IsLoad;
	logic [$clog2(LsqDepth)-1:0] s1Id;
	logic                        s1FwdHit;
	dataT                        s1FwdData;   // store data caught in the agen cycle
	dataT                        s2Data;

	// forwarded word beats memory, stores complete with zero
	assign s2Data = !s1IsLoad ? '0 : (s1FwdHit ? s1FwdData : ldData_i);

	always_ff @(posedge clk)
	begin
		if (reset || recoverFlag_i)
		begin
			s1Valid   <= 1'b0;
			wbValid_o <= 1'b0;
		end
		else
		begin
			s1Valid   <= memValid_i;
			wbValid_o <= s1Valid;
		end
	end

	always_ff @(posedge clk)
	begin
		s1IsLoad   <= memIsLoad_i;
		s1Id       <= memLsqId_i;
		s1FwdHit   <= fwdHit_i;
		s1FwdData  <= fwdData_i;
		wbIsLoad_o <= s1IsLoad;
		wbLsqId_o  <= s1Id;
		wbData_o   <= s2Data;   // ldData_i is in this cycle
	end

endmodule

// ==== hw/lsqControl.sv ====
`timescale 1ns/10ps

module lsqControl #(
	parameter int LsqDepth = lsuCfgPkg::DefaultLsqDepth
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         recoverFlag_i,
	input  logic                         dispatchReady_i,
	input  logic                         dispatchIsLoad_i,
	input  logic                         commitLoad_i,
	input  logic                         commitStore_i,
	input  logic                         memValid_i,
	input  logic                         memIsLoad_i,
	input  logic [$clog2(LsqDepth)-1:0]  memLsqId_i,
	input  lsuPktPkg::stqEntryT          stqHeadEntry_i,
	output logic [$clog2(LsqDepth)-1:0]  lsqId_o,
	output logic [$clog2(LsqDepth):0]    ldqCount_o,
	output logic [$clog2(LsqDepth):0]    stqCount_o,
	output logic [$clog2(LsqDepth)-1:0]  ldqHead_o,
	output logic [$clog2(LsqDepth)-1:0]  ldqTail_o,
	output logic [$clog2(LsqDepth)-1:0]  stqHead_o,
	output logic [$clog2(LsqDepth)-1:0]  stqTail_o,
	output logic                         ldqAlloc_o,
	output logic                         stqAlloc_o,
	output logic [$clog2(LsqDepth)-1:0]  agenBound_o,
	output logic                         stEn_o,
	output lsuPktPkg::addrT              stAddr_o,
	output lsuPktPkg::dataT              stData_o
);

	localparam int IdxW = $clog2(LsqDepth);
	localparam int CntW = IdxW + 1;

	logic [IdxW-1:0] ldqHead, ldqTail;
	logic [IdxW-1:0] stqHead, stqTail;
	logic [CntW-1:0] ldqCount, stqCount;
	logic            ldqCommit, stqCommit;   // commit strobes that hit a live entry
	logic [IdxW-1:0] ldBound [LsqDepth];      // per load, store tail at dispatch
	logic [IdxW-1:0] stBound [LsqDepth];      // per store, load tail at dispatch

	// dispatch to a full queue is dropped
	assign ldqAlloc_o = dispatchReady_i & dispatchIsLoad_i & (ldqCount != CntW'(LsqDepth));
	assign stqAlloc_o = dispatchReady_i & ~dispatchIsLoad_i & (stqCount != CntW'(LsqDepth));

	assign ldqCommit = commitLoad_i & (ldqCount != '0);   // ignored when empty
	assign stqCommit = commitStore_i & (stqCount != '0);

	assign lsqId_o = dispatchIsLoad_i ? ldqTail : stqTail;   // id is the tail slot

	assign ldqHead_o  = ldqHead;
	assign ldqTail_o  = ldqTail;
	assign stqHead_o  = stqHead;
	assign stqTail_o  = stqTail;
	assign ldqCount_o = ldqCount;
	assign stqCount_o = stqCount;

	// boundary of the agen packet's own entry, quiet when idle
	always_comb
	begin
		if (!memValid_i)
			agenBound_o = '0;
		else if (memIsLoad_i)
			agenBound_o = ldBound[memLsqId_i];   // first store younger than the load
		else
			agenBound_o = stBound[memLsqId_i];   // first load younger than the store
	end

	// load queue pointers and count
	always_ff @(posedge clk)
	begin
		if (reset || recoverFlag_i)
		begin
			ldqHead  <= '0;
			ldqTail  <= '0;
			ldqCount <= '0;
		end
		else
		begin
			if (ldqAlloc_o)
				ldqTail <= ldqTail + 1'b1;   // wraps at depth
			if (ldqCommit)
				ldqHead <= ldqHead + 1'b1;
			ldqCount <= ldqCount + CntW'(ldqAlloc_o) - CntW'(ldqCommit);
		end
	end

	// store queue pointers and count
	always_ff @(posedge clk)
	begin
		if (reset || recoverFlag_i)
		begin
			stqHead  <= '0;
			stqTail  <= '0;
			stqCount <= '0;
		end
		else
		begin
			if (stqAlloc_o)
				stqTail <= stqTail + 1'b1;
			if (stqCommit)
				stqHead <= stqHead + 1'b1;
			stqCount <= stqCount + CntW'(stqAlloc_o) - CntW'(stqCommit);
		end
	end

	// age boundaries, written once per allocation
	always_ff @(posedge clk)
	begin
		if (ldqAlloc_o)
			ldBound[ldqTail] <= stqTail;
		if (stqAlloc_o)
			stBound[stqTail] <= ldqTail;
	end

	// store write port, one cycle after commit
	always_ff @(posedge clk)
	begin
		if (reset)
			stEn_o <= 1'b0;
		else
			stEn_o <= stqCommit;
	end

	always_ff @(posedge clk)
	begin
		if (stqCommit)
		begin
			stAddr_o <= stqHeadEntry_i.addr;   // head store leaves in order
			stData_o <= stqHeadEntry_i.data;
		end
	end

endmodule

// ==== hw/lsuTop.sv ====
`timescale 1ns/10ps

module lsuTop #(
	parameter int LsqDepth = lsuCfgPkg::DefaultLsqDepth
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         recoverFlag_i,
	input  logic                         dispatchReady_i,
	input  logic                         dispatchIsLoad_i,
	input  logic                         commitLoad_i,
	input  logic                         commitStore_i,
	input  logic                         memValid_i,
	input  logic                         memIsLoad_i,
	input  logic [$clog2(LsqDepth)-1:0]  memLsqId_i,
	input  lsuPktPkg::addrT              memAddr_i,
	input  lsuPktPkg::dataT              memData_i,
	input  lsuPktPkg::dataT              ldData_i,
	output logic [$clog2(LsqDepth)-1:0]  lsqId_o,
	output logic [$clog2(LsqDepth):0]    ldqCount_o,
	output logic [$clog2(LsqDepth):0]    stqCount_o,
	output logic                         ldEn_o,
	output lsuPktPkg::addrT              ldAddr_o,
	output logic                         stEn_o,
	output lsuPktPkg::addrT              stAddr_o,
	output lsuPktPkg::dataT              stData_o,
	output logic                         wbValid_o,
	output logic                         wbIsLoad_o,
	output logic [$clog2(LsqDepth)-1:0]  wbLsqId_o,
	output lsuPktPkg::dataT              wbData_o,
	output logic                         ldVioValid_o,
	output logic [$clog2(LsqDepth)-1:0]  ldVioLsqId_o
);

	import lsuPktPkg::*;

	localparam int IdxW = $clog2(LsqDepth);

	logic [IdxW-1:0] ldqHead, ldqTail;         // load queue pointers
	logic [IdxW-1:0] stqHead, stqTail;         // store queue pointers
	logic            ldqAlloc, stqAlloc;       // dispatch writes
	logic [IdxW-1:0] agenBound;                // age boundary of the agen packet
	logic            ldqUpd, stqUpd;           // agen writes
	ldqEntryT        ldqUpdEntry;
	stqEntryT        stqUpdEntry;
	ldqEntryT        ldqEntries [LsqDepth];
	stqEntryT        stqEntries [LsqDepth];
	stqEntryT        stqHeadEntry;             // oldest store, for commit
	logic            fwdHit;
	dataT            fwdData;

	// loads go to memory in the agen cycle
	assign ldEn_o   = memValid_i & memIsLoad_i;
	assign ldAddr_o = memAddr_i;

	assign ldqUpd = ldEn_o;
	assign stqUpd = memValid_i & ~memIsLoad_i;

	assign ldqUpdEntry = '{executed: 1'b1, addr: memAddr_i};
	assign stqUpdEntry = '{addrValid: 1'b1, addr: memAddr_i, data: memData_i};

	lsqControl #(
		.LsqDepth (LsqDepth)
	) control (
		.clk              (clk),
		.reset            (reset),
		.recoverFlag_i    (recoverFlag_i),
		.dispatchReady_i  (dispatchReady_i),
		.dispatchIsLoad_i (dispatchIsLoad_i),
		.commitLoad_i     (commitLoad_i),
		.commitStore_i    (commitStore_i),
		.memValid_i       (memValid_i),
		.memIsLoad_i      (memIsLoad_i),
		.memLsqId_i       (memLsqId_i),
		.stqHeadEntry_i   (stqHeadEntry),
		.lsqId_o          (lsqId_o),
		.ldqCount_o       (ldqCount_o),
		.stqCount_o       (stqCount_o),
		.ldqHead_o        (ldqHead),
		.ldqTail_o        (ldqTail),
		.stqHead_o        (stqHead),
		.stqTail_o        (stqTail),
		.ldqAlloc_o       (ldqAlloc),
		.stqAlloc_o       (stqAlloc),
		.agenBound_o      (agenBound),
		.stEn_o           (stEn_o),
		.stAddr_o         (stAddr_o),
		.stData_o         (stData_o)
	);

	lsqEntryRam #(
		.LsqDepth (LsqDepth),
		.EntryT   (ldqEntryT)
	) ldqRam (
		.clk         (clk),
		.reset       (reset),
		.clear_i     (recoverFlag_i),
		.alloc_i     (ldqAlloc),
		.allocIdx_i  (ldqTail),
		.updEn_i     (ldqUpd),
		.updIdx_i    (memLsqId_i),
		.updEntry_i  (ldqUpdEntry),
		.headIdx_i   (ldqHead),
		.entries_o   (ldqEntries),
		.headEntry_o ()                         // load commit needs no payload
	);

	lsqEntryRam #(
		.LsqDepth (LsqDepth),
		.EntryT   (stqEntryT)
	) stqRam (
		.clk         (clk),
		.reset       (reset),
		.clear_i     (recoverFlag_i),
		.alloc_i     (stqAlloc),
		.allocIdx_i  (stqTail),
		.updEn_i     (stqUpd),
		.updIdx_i    (memLsqId_i),
		.updEntry_i  (stqUpdEntry),
		.headIdx_i   (stqHead),
		.entries_o   (stqEntries),
		.headEntry_o (stqHeadEntry)
	);

	storeForwardCam #(
		.LsqDepth (LsqDepth)
	) fwdCam (
		.loadAddr_i   (memAddr_i),
		.stqHead_i    (stqHead),
		.stqBound_i   (agenBound),
		.stqEntries_i (stqEntries),
		.fwdHit_o     (fwdHit),
		.fwdData_o    (fwdData)
	);

	loadViolationCam #(
		.LsqDepth (LsqDepth)
	) vioCam (
		.clk          (clk),
		.reset        (reset),
		.recoverFlag_i(recoverFlag_i),
		.storeValid_i (stqUpd),
		.storeAddr_i  (memAddr_i),
		.ldqBound_i   (agenBound),
		.ldqTail_i    (ldqTail),
		.ldqEntries_i (ldqEntries),
		.ldVioValid_o (ldVioValid_o),
		.ldVioLsqId_o (ldVioLsqId_o)
	);

	lsuWriteback #(
		.LsqDepth (LsqDepth)
	) writeback (
		.clk          (clk),
		.reset        (reset),
		.recoverFlag_i(recoverFlag_i),
		.memValid_i   (memValid_i),
		.memIsLoad_i  (memIsLoad_i),
		.memLsqId_i   (memLsqId_i),
		.fwdHit_i     (fwdHit),
		.fwdData_i    (fwdData),
		.ldData_i     (ldData_i),
		.wbValid_o    (wbValid_o),
		.wbIsLoad_o   (wbIsLoad_o),
		.wbLsqId_o    (wbLsqId_o),
		.wbData_o     (wbData_o)
	);

endmodule

// ==== verif/lsuTbTasks.svh ====
`ifndef LSU_TB_TASKS_SVH
`define LSU_TB_TASKS_SVH

task automatic reportValue(input string name, input logic [63:0] exp, input logic [63:0] act);
	valueErrors++;
	$display("CHECK FAILED time %0t: %s expected %0h, got %0h", $time, name, exp, act);
endtask

task automatic reportError(input string msg);
	otherErrors++;
	$display("ERROR time %0t: %s", $time, msg);
endtask

task automatic checkData(input string name, input dataT exp, input dataT act);
	if (act !== exp)
		reportValue(name, exp, act);
endtask

task automatic checkAddr(input string name, input addrT exp, input addrT act);
	if (act !== exp)
		reportValue(name, exp, act);
endtask

task automatic checkId(input string name, input idT exp, input idT act);
	if (act !== exp)
		reportValue(name, exp, act);
endtask

task automatic checkCount(input string name, input cntT exp, input cntT act);
	if (act !== exp)
		reportValue(name, exp, act);
endtask

task automatic checkFlag(input string name, input logic exp, input logic act);
	if (act !== exp)
		reportValue(name, exp, act);
endtask

// all tasks start and end on a falling edge
task automatic dispatchExpect(input logic isLoad, input idT expId);
	dispatchReady  = 1'b1;
	dispatchIsLoad = isLoad;
	#(ClkPeriod / 4);                     // id is combinational, let it settle
	checkId("lsqId_o", expId, lsqId);
	@(negedge clk);
	dispatchReady  = 1'b0;
endtask

task automatic sendPacket(input logic isLoad, input idT id, input addrT addr,
	input dataT data, output int driveCycle);
	memValid   = 1'b1;
	memIsLoad  = isLoad;
	memLsqId   = id;
	memAddr    = addr;
	memData    = data;
	driveCycle = cycleCnt;                // sampled on the next rising edge
	#(ClkPeriod / 4);                     // memory read port follows the packet
	checkFlag("ldEn_o", isLoad, ldEn);
	if (isLoad)
		checkAddr("ldAddr_o", addr, ldAddr);
	@(negedge clk);
	memValid   = 1'b0;
endtask

task automatic pulseCommit(input logic isLoad, output int driveCycle);
	commitLoad  = isLoad;
	commitStore = !isLoad;
	driveCycle  = cycleCnt;
	@(negedge clk);
	commitLoad  = 1'b0;
	commitStore = 1'b0;
endtask

task automatic recover();
	recoverFlag = 1'b1;
	@(negedge clk);
	recoverFlag = 1'b0;
endtask

// waits for one writeback, checks it, then steps past it
task automatic expectWb(input logic isLoad, input idT id, input dataT data, input int driveCycle);
	int waited;
	waited = 0;
	while (!wbValid && waited < WaitLimit)
	begin
		@(negedge clk);
		waited++;
	end
	if (!wbValid)
		reportError($sformatf("no writeback for queue id %0d", id));
	else
	begin
		checkFlag("wbIsLoad_o", isLoad, wbIsLoad);
		checkId("wbLsqId_o", id, wbLsqId);
		checkData("wbData_o", data, wbData);
		if (cycleCnt - driveCycle != 2)
			reportError($sformatf("writeback for id %0d came %0d cycles after its packet",
				id, cycleCnt - driveCycle));
	end
	@(negedge clk);
endtask

task automatic expectVio(input idT id, input int driveCycle);
	int waited;
	waited = 0;
	while (!ldVioValid && waited < WaitLimit)
	begin
		@(negedge clk);
		waited++;
	end
	if (!ldVioValid)
		reportError($sformatf("no load violation raised for load %0d", id));
	else
	begin
		checkId("ldVioLsqId_o", id, ldVioLsqId);
		if (cycleCnt - driveCycle != 1)
			reportError("load violation did not follow the store by one cycle");
	end
	@(negedge clk);
	checkFlag("ldVioValid_o", 1'b0, ldVioValid);   // single-cycle report
endtask

task automatic expectStWrite(input addrT addr, input dataT data, input int driveCycle);
	int waited;
	waited = 0;
	while (!stEn && waited < WaitLimit)
	begin
		@(negedge clk);
		waited++;
	end
	if (!stEn)
		reportError("store commit never reached the memory write port");
	else
	begin
		checkAddr("stAddr_o", addr, stAddr);
		checkData("stData_o", data, stData);
		if (cycleCnt - driveCycle != 1)
			reportError("store write did not follow its commit by one cycle");
	end
	@(negedge clk);
endtask

task automatic checkResetState();
	checkFlag("wbValid_o", 1'b0, wbValid);
	checkFlag("ldVioValid_o", 1'b0, ldVioValid);
	checkFlag("stEn_o", 1'b0, stEn);
	checkFlag("ldEn_o", 1'b0, ldEn);
	checkCount("ldqCount_o", '0, ldqCount);
	checkCount("stqCount_o", '0, stqCount);
endtask

// ids follow each queue's tail, full queues hold their count
task automatic testDispatch();
	idT          ldTail;
	idT          stTail;
	cntT         ldCnt;
	cntT         stCnt;
	logic [31:0] r;
	ldTail = '0;
	stTail = '0;
	ldCnt  = '0;
	stCnt  = '0;
	for (int i = 0; i < 3 * Depth; i++)
	begin
		r = nextRand();
		dispatchExpect(r[0], r[0] ? ldTail : stTail);
		if (r[0] && ldCnt != cntT'(Depth))
		begin
			ldCnt++;
			ldTail = idT'((int'(ldTail) + 1) % Depth);
		end
		else if (!r[0] && stCnt != cntT'(Depth))
		begin
			stCnt++;
			stTail = idT'((int'(stTail) + 1) % Depth);
		end
		checkCount("ldqCount_o", ldCnt, ldqCount);
		checkCount("stqCount_o", stCnt, stqCount);
	end
	recover();
endtask

task automatic testLoadMemory();
	addrT a0, a1, a2;
	int   c0, c1, c2;
	a0 = nextRand();
	a1 = nextRand();
	a2 = nextRand();
	dispatchExpect(1'b1, 0);
	dispatchExpect(1'b1, 1);
	dispatchExpect(1'b1, 2);
	sendPacket(1'b1, 0, a0, '0, c0);
	expectWb(1'b1, 0, memWord(a0), c0);
	sendPacket(1'b1, 1, a1, '0, c1);
	sendPacket(1'b1, 2, a2, '0, c2);   // back to back, both in flight
	expectWb(1'b1, 1, memWord(a1), c1);
	expectWb(1'b1, 2, memWord(a2), c2);
	recover();
endtask

// store order S0 S1 S2 L0 S3, S2 never gets an address
task automatic testForwarding();
	addrT a;
	dataT d0, d1, d3;
	int   c;
	a  = nextRand();
	d0 = nextRand();
	d1 = nextRand();
	d3 = nextRand();
	dispatchExpect(1'b0, 0);
	dispatchExpect(1'b0, 1);
	dispatchExpect(1'b0, 2);
	dispatchExpect(1'b1, 0);
	dispatchExpect(1'b0, 3);
	sendPacket(1'b0, 0, a, d0, c);
	expectWb(1'b0, 0, '0, c);
	sendPacket(1'b0, 1, a, d1, c);
	expectWb(1'b0, 1, '0, c);
	sendPacket(1'b0, 3, a, d3, c);       // younger store, not a source
	expectWb(1'b0, 3, '0, c);
	sendPacket(1'b1, 0, a, '0, c);
	expectWb(1'b1, 0, d1, c);            // youngest older known store
	recover();
endtask

task automatic testViolation();
	addrT a;
	int   c;
	a = nextRand();
	dispatchExpect(1'b0, 0);
	dispatchExpect(1'b0, 1);
	dispatchExpect(1'b1, 0);
	dispatchExpect(1'b1, 1);
	sendPacket(1'b1, 0, a, '0, c);
	expectWb(1'b1, 0, memWord(a), c);
	sendPacket(1'b1, 1, a + 1, '0, c);
	expectWb(1'b1, 1, memWord(a + 1), c);
	sendPacket(1'b0, 1, a + 2, nextRand(), c);   // no load at this word
	checkFlag("ldVioValid_o", 1'b0, ldVioValid);
	expectWb(1'b0, 1, '0, c);
	sendPacket(1'b0, 0, a + 1, nextRand(), c);   // hits executed load 1
	expectVio(1, c);
	expectWb(1'b0, 0, '0, c);
	recover();
endtask

task automatic testCommit();
	addrT a0, a1;
	dataT d0, d1;
	int   c;
	a0 = nextRand();
	a1 = nextRand();
	d0 = nextRand();
	d1 = nextRand();
	dispatchExpect(1'b0, 0);
	dispatchExpect(1'b0, 1);
	dispatchExpect(1'b1, 0);
	sendPacket(1'b0, 0, a0, d0, c);
	expectWb(1'b0, 0, '0, c);
	sendPacket(1'b0, 1, a1, d1, c);
	expectWb(1'b0, 1, '0, c);
	pulseCommit(1'b0, c);
	expectStWrite(a0, d0, c);            // oldest store first
	checkCount("stqCount_o", 1, stqCount);
	pulseCommit(1'b0, c);
	expectStWrite(a1, d1, c);
	checkCount("stqCount_o", 0, stqCount);
	pulseCommit(1'b0, c);                // empty queue, no write
	checkFlag("stEn_o", 1'b0, stEn);
	pulseCommit(1'b1, c);
	checkCount("ldqCount_o", 0, ldqCount);
	pulseCommit(1'b1, c);
	checkCount("ldqCount_o", 0, ldqCount);
	recover();
endtask

task automatic testRecovery();
	int c;
	dispatchExpect(1'b1, 0);
	dispatchExpect(1'b1, 1);
	dispatchExpect(1'b0, 0);
	sendPacket(1'b1, 0, nextRand(), '0, c);
	recover();                           // load still in stage one
	checkFlag("wbValid_o", 1'b0, wbValid);
	checkCount("ldqCount_o", 0, ldqCount);
	checkCount("stqCount_o", 0, stqCount);
	@(negedge clk);
	checkFlag("wbValid_o", 1'b0, wbValid);
	dispatchExpect(1'b1, 0);             // pointers back at zero
	dispatchExpect(1'b0, 0);
	recover();
endtask

`endif

// ==== verif/lsuTb.sv ====
`timescale 1ns/10ps

module lsuTb;

	import lsuPktPkg::*;

	localparam int Depth        = lsuCfgPkg::DefaultLsqDepth;
	localparam int IdxW         = $clog2(Depth);
	localparam int ClkPeriod    = 8;
	localparam int ResetCycles  = 16;
	localparam int WaitLimit    = 10;   // cycles before a missing result is reported
	// per test: dispatch, load, forward, violation, commit, recovery
	localparam int TestCycles   = (3 * Depth + 10) + 20 + 30 + 40 + 30 + 25;
	localparam int MarginCycles = 100;

	typedef logic [IdxW-1:0] idT;       // queue identifier
	typedef logic [IdxW:0]   cntT;      // queue occupancy

	logic        clk;
	logic        reset;
	logic        recoverFlag;
	logic        dispatchReady;
	logic        dispatchIsLoad;
	logic        commitLoad;
	logic        commitStore;
	logic        memValid;
	logic        memIsLoad;
	idT          memLsqId;
	addrT        memAddr;
	dataT        memData;
	dataT        ldData;            // driven by the memory model
	idT          lsqId;
	cntT         ldqCount;
	cntT         stqCount;
	logic        ldEn;
	addrT        ldAddr;
	logic        stEn;
	addrT        stAddr;
	dataT        stData;
	logic        wbValid;
	logic        wbIsLoad;
	idT          wbLsqId;
	dataT        wbData;
	logic        ldVioValid;
	idT          ldVioLsqId;

	int          cycleCnt;          // rising edges since time zero
	int          valueErrors;
	int          otherErrors;
	logic [31:0] randState;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// memory image, a hash of the full word address
	function automatic dataT memWord(input addrT a);
		return xorshift32(a);
	endfunction

	function automatic logic [31:0] nextRand();
		randState = xorshift32(randState);
		return randState;
	endfunction

	`include "lsuTbTasks.svh"

	lsuTop #(
		.LsqDepth (Depth)
	) i_dut (
		.clk              (clk),
		.reset            (reset),
		.recoverFlag_i    (recoverFlag),
		.dispatchReady_i  (dispatchReady),
		.dispatchIsLoad_i (dispatchIsLoad),
		.commitLoad_i     (commitLoad),
		.commitStore_i    (commitStore),
		.memValid_i       (memValid),
		.memIsLoad_i      (memIsLoad),
		.memLsqId_i       (memLsqId),
		.memAddr_i        (memAddr),
		.memData_i        (memData),
		.ldData_i         (ldData),
		.lsqId_o          (lsqId),
		.ldqCount_o       (ldqCount),
		.stqCount_o       (stqCount),
		.ldEn_o           (ldEn),
		.ldAddr_o         (ldAddr),
		.stEn_o           (stEn),
		.stAddr_o         (stAddr),
		.stData_o         (stData),
		.wbValid_o        (wbValid),
		.wbIsLoad_o       (wbIsLoad),
		.wbLsqId_o        (wbLsqId),
		.wbData_o         (wbData),
		.ldVioValid_o     (ldVioValid),
		.ldVioLsqId_o     (ldVioLsqId)
	);

	initial
		clk = 1'b0;
	always #(ClkPeriod / 2) clk = ~clk;

	always @(posedge clk)
		cycleCnt <= cycleCnt + 1;

	// memory answers one cycle after the read
	always @(posedge clk)
	begin
		if (ldEn)
			ldData <= memWord(ldAddr);
	end

	initial
	begin
		#(ClkPeriod * (ResetCycles + TestCycles + MarginCycles));
		$display("watchdog: run exceeded its budget of %0d cycles",
			ResetCycles + TestCycles + MarginCycles);
		$display("tests failed");
		$finish;
	end

	initial
	begin
		reset          = 1'b1;
		recoverFlag    = 1'b0;
		dispatchReady  = 1'b0;
		dispatchIsLoad = 1'b0;
		commitLoad     = 1'b0;
		commitStore    = 1'b0;
		memValid       = 1'b0;
		memIsLoad      = 1'b0;
		memLsqId       = '0;
		memAddr        = '0;
		memData        = '0;
		ldData         = '0;
		cycleCnt       = 0;
		valueErrors    = 0;
		otherErrors    = 0;
		randState      = 32'd80;        // fixed seed
		repeat (ResetCycles) @(negedge clk);
		reset = 1'b0;
		checkResetState();
		testDispatch();
		testLoadMemory();
		testForwarding();
		testViolation();
		testCommit();
		testRecovery();
		$display("summary: %0d value errors, %0d other errors", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+verif
hw/lsuCfgPkg.sv
hw/lsuPktPkg.sv
hw/lsqEntryRam.sv
hw/storeForwardCam.sv
hw/loadViolationCam.sv
hw/lsuWriteback.sv
hw/lsqControl.sv
hw/lsuTop.sv
verif/lsuTb.sv
